// ==== sim.f ====
verilog/pipe_pkg.sv
verilog/hazard_control_unit.sv
verilog/stage_reg.sv
verilog/fetch_stage.sv
verilog/pipe_core_top.sv
test/tb_pipe_core.sv

// ==== Makefile ====
# Verilator flow for the pipeline hazard model.
VERILATOR ?= verilator
TOP       ?= tb_pipe_core
RTL_TOP   ?= pipe_core_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_pipe_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_core
    import pipe_pkg::*;
;

    localparam int burst_n = 24;   // back-to-back plain descriptors.
    localparam int random_n = 150;
    localparam int n_real = burst_n + random_n;
    localparam int wait_limit = 200;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   in_valid = 1'b0;
    logic [tag_w-1:0]       in_tag = '0;
    logic [reg_addr_w-1:0]  in_rs1 = '0;
    logic [reg_addr_w-1:0]  in_rs2 = '0;
    logic [reg_addr_w-1:0]  in_rd = '0;
    logic [load_kind_w-1:0] in_load = '0;
    logic                   in_mispredict = 1'b0;
    logic                   out_ready = 1'b0;
    logic                   in_ready;
    logic                   out_valid;
    logic [tag_w-1:0]       out_tag;
    logic [reg_addr_w-1:0]  out_rd;
    logic [load_kind_w-1:0] out_load;

    // tags index the scoreboard and never wrap in one run.
    logic                   accepted [256];
    logic                   retired [256];
    logic [reg_addr_w-1:0]  acc_rs1 [256];
    logic [reg_addr_w-1:0]  acc_rs2 [256];
    logic [reg_addr_w-1:0]  acc_rd [256];
    logic [load_kind_w-1:0] acc_load [256];
    logic                   acc_misp [256];
    int                     ret_cycle [256];

    int   cycle = 0;  // cycles the pipe was not frozen.
    int   last_ret = -1;
    int   mism = 0;
    int   other = 0;
    logic hung = 1'b0;
    logic bp_on = 1'b0;  // random back-pressure.

    logic                   hold_pending = 1'b0;
    logic [tag_w-1:0]       hold_tag;
    logic [reg_addr_w-1:0]  hold_rd;
    logic [load_kind_w-1:0] hold_load;

    pipe_core_top u_dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_tag(in_tag),
        .in_rs1(in_rs1), .in_rs2(in_rs2), .in_rd(in_rd), .in_load(in_load),
        .in_mispredict(in_mispredict), .out_ready(out_ready), .in_ready(in_ready),
        .out_valid(out_valid), .out_tag(out_tag), .out_rd(out_rd), .out_load(out_load)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        if (!(out_valid && !out_ready))
            cycle <= cycle + 1;
        out_ready <= bp_on ? (($urandom % 4) != 0) : 1'b1;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~
    assert property (@(posedge clk) $rose(rst_n) |-> (!out_valid && in_ready))
        else
        begin
            mism++;
            $display("MISMATCH out_valid=%h in_ready=%h after reset",
                     $sampled(out_valid), $sampled(in_ready));
        end

    always @(posedge clk)
    begin
        if (rst_n && hold_pending)
            assert (out_valid && out_tag == hold_tag && out_rd == hold_rd
                    && out_load == hold_load)
                else
                begin
                    mism++;
                    $display("MISMATCH out_tag/out_rd/out_load held %h/%h/%h now %h/%h/%h",
                             hold_tag, hold_rd, hold_load, out_tag, out_rd, out_load);
                end
        hold_pending <= rst_n && out_valid && !out_ready;
        hold_tag     <= out_tag;
        hold_rd      <= out_rd;
        hold_load    <= out_load;
    end

    always @(posedge clk)
    begin
        if (rst_n && in_valid && in_ready)
        begin
            accepted[in_tag] <= 1'b1;
            acc_rs1[in_tag]  <= in_rs1;
            acc_rs2[in_tag]  <= in_rs2;
            acc_rd[in_tag]   <= in_rd;
            acc_load[in_tag] <= in_load;
            acc_misp[in_tag] <= in_mispredict;
        end
    end

    always @(posedge clk)
    begin
        int t;
        if (rst_n && out_valid && out_ready)
        begin
            t = int'(out_tag);
            assert (accepted[t] && t > last_ret)
                else
                begin
                    mism++;
                    $display("MISMATCH out_tag=%h after %h", out_tag, last_ret[tag_w-1:0]);
                end
            assert (out_rd == acc_rd[t] && out_load == acc_load[t])
                else
                begin
                    mism++;
                    $display("MISMATCH out_rd=%h exp %h out_load=%h exp %h",
                             out_rd, acc_rd[t], out_load, acc_load[t]);
                end
            // skipped tags must sit in the flush shadow of a mispredict.
            for (int s = last_ret + 1; s < t; s++)
                assert (!acc_misp[s]
                        && ((s >= 1 && acc_misp[s-1]) || (s >= 2 && acc_misp[s-2])))
                    else
                    begin
                        other++;
                        $display("descriptor %0d was dropped against the flush rule", s);
                    end
            for (int a = t - 3; a < t; a++)
                if (a >= 0 && retired[a] && acc_load[a] != load_none
                    && (acc_rs1[t] == acc_rd[a] || acc_rs2[t] == acc_rd[a]))
                    assert (cycle - ret_cycle[a] >= 4)
                        else
                        begin
                            mism++;
                            $display("MISMATCH retire gap tag %h after load %h: %h cycles",
                                     out_tag, a[tag_w-1:0], cycle - ret_cycle[a]);
                        end
            retired[t]   = 1'b1;
            ret_cycle[t] = cycle;
            last_ret     = t;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic send(input int t, input logic [reg_addr_w-1:0] rs1,
                        input logic [reg_addr_w-1:0] rs2, input logic [reg_addr_w-1:0] rd,
                        input logic [load_kind_w-1:0] ld, input logic mp);
        int waited;
        waited = 0;
        in_valid      <= 1'b1;
        in_tag        <= t[tag_w-1:0];
        in_rs1        <= rs1;
        in_rs2        <= rs2;
        in_rd         <= rd;
        in_load       <= ld;
        in_mispredict <= mp;
        @(posedge clk);
        while (!in_ready)
        begin
            waited++;
            if (waited > wait_limit)
            begin
                other++;
                hung = 1'b1;
                $display("timeout waiting for in_ready on tag %0d", t);
                return;
            end
            @(posedge clk);
        end
    endtask

    function automatic logic [reg_addr_w-1:0] small_reg();
        return reg_addr_w'($urandom % 4);  // x0..x3 so load-use is common.
    endfunction

    task automatic run_all();
        logic [load_kind_w-1:0] ld;
        logic                   mp;
        int shadow;
        int fill;
        for (int i = 0; i < burst_n && !hung; i++)
            send(i, small_reg(), small_reg(), small_reg(), load_none, 1'b0);
        bp_on <= 1'b1;
        shadow = 0;
        for (int i = burst_n; i < n_real && !hung; i++)
        begin
            ld = (($urandom % 100) < 30) ? load_kind_w'(1 + $urandom % 5) : load_none;
            // no flag inside an earlier flag's flush shadow.
            mp     = (shadow == 0) && (($urandom % 100) < 5);
            shadow = mp ? 2 : ((shadow > 0) ? shadow - 1 : 0);
            send(i, small_reg(), small_reg(), small_reg(), ld, mp);
            if (!hung && ($urandom % 100) < 20)
            begin
                in_valid <= 1'b0;
                repeat (1 + $urandom % 3) @(posedge clk);
            end
        end
        bp_on <= 1'b0;
        fill  = 0;
        // the front end only moves with fetch, so push fillers to drain.
        while (!hung && last_ret < n_real - 1)
        begin
            if (fill >= 60)
            begin
                other++;
                hung = 1'b1;
                $display("pipeline did not drain after %0d fillers", fill);
            end
            else
            begin
                send(n_real + fill, 5'd0, 5'd0, 5'd0, load_none, 1'b0);
                fill++;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h7495));
        for (int i = 0; i < 256; i++)
        begin
            accepted[i] = 1'b0;
            retired[i]  = 1'b0;
            acc_misp[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        run_all();
        for (int k = 0; k < 15; k++)
            assert (retired[k] && retired[k+1] && ret_cycle[k+1] == ret_cycle[k] + 1)
                else
                begin
                    mism++;
                    $display("MISMATCH burst retire cycle tag %h=%h tag %h=%h", k[tag_w-1:0],
                             ret_cycle[k], k[tag_w-1:0] + 1'b1, ret_cycle[k+1]);
                end
        $display("errors: %0d mismatch, %0d other", mism, other);
        if (mism == 0 && other == 0 && !hung)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_core_top
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [tag_w-1:0]       in_tag,
    input  logic [reg_addr_w-1:0]  in_rs1,
    input  logic [reg_addr_w-1:0]  in_rs2,
    input  logic [reg_addr_w-1:0]  in_rd,
    input  logic [load_kind_w-1:0] in_load,
    input  logic                   in_mispredict,
    input  logic                   out_ready,
    output logic                   in_ready,
    output logic                   out_valid,
    output logic [tag_w-1:0]       out_tag,
    output logic [reg_addr_w-1:0]  out_rd,
    output logic [load_kind_w-1:0] out_load
);

    logic   if_valid;
    instr_t if_payload;
    logic   id_valid;
    instr_t id_payload;
    logic   ex_valid;
    instr_t ex_payload;
    mem_t   ex_mem;
    logic   dm1_valid;
    mem_t   dm1_payload;
    logic   dm2_valid;
    mem_t   dm2_payload;
    logic   dm3_valid;
    mem_t   dm3_payload;
    logic   wb_valid;
    mem_t   wb_payload;

    logic clear_if;
    logic clear_id;
    logic clear_ex;
    logic clear_dm1;
    logic stall_pc_if;
    logic stall_id;
    logic stall_ex;
    logic stall_dm;

    logic                   out_stall_req;
    logic                   ex_mispredict;
    logic [load_kind_w-1:0] dm1_load;
    logic [load_kind_w-1:0] dm2_load;
    logic [load_kind_w-1:0] dm3_load;

    // ~~~~~~~~~~~~~~~~~~~~
    // front end
    // ~~~~~~~~~~~~~~~~~~~~
    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall_pc_if),
        .clear         (clear_if),
        .in_valid      (in_valid),
        .in_tag        (in_tag),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_rd         (in_rd),
        .in_load       (in_load),
        .in_mispredict (in_mispredict),
        .in_ready      (in_ready),
        .if_valid      (if_valid),
        .if_payload    (if_payload)
    );

    stage_reg #(.payload_t(instr_t)) u_id (
        .clk(clk), .rst_n(rst_n), .stall(stall_id), .clear(clear_id),
        .in_valid(if_valid), .in_payload(if_payload),
        .out_valid(id_valid), .out_payload(id_payload)
    );

    stage_reg #(.payload_t(instr_t)) u_ex (
        .clk(clk), .rst_n(rst_n), .stall(stall_ex), .clear(clear_ex),
        .in_valid(id_valid), .in_payload(id_payload),
        .out_valid(ex_valid), .out_payload(ex_payload)
    );

    // operands and branch bit stop at EX.
    assign ex_mem = '{tag: ex_payload.tag, rd: ex_payload.rd, load_kind: ex_payload.load_kind};

    // ~~~~~~~~~~~~~~~~~~~~
    // memory and writeback
    // ~~~~~~~~~~~~~~~~~~~~
    assign clear_dm1 = stall_ex && !stall_dm;  // EX held, DM keeps draining.

    stage_reg #(.payload_t(mem_t)) u_dm1 (
        .clk(clk), .rst_n(rst_n), .stall(stall_dm), .clear(clear_dm1),
        .in_valid(ex_valid), .in_payload(ex_mem),
        .out_valid(dm1_valid), .out_payload(dm1_payload)
    );

    stage_reg #(.payload_t(mem_t)) u_dm2 (
        .clk(clk), .rst_n(rst_n), .stall(stall_dm), .clear(1'b0),
        .in_valid(dm1_valid), .in_payload(dm1_payload),
        .out_valid(dm2_valid), .out_payload(dm2_payload)
    );

    stage_reg #(.payload_t(mem_t)) u_dm3 (
        .clk(clk), .rst_n(rst_n), .stall(stall_dm), .clear(1'b0),
        .in_valid(dm2_valid), .in_payload(dm2_payload),
        .out_valid(dm3_valid), .out_payload(dm3_payload)
    );

    stage_reg #(.payload_t(mem_t)) u_wb (
        .clk(clk), .rst_n(rst_n), .stall(stall_dm), .clear(1'b0),
        .in_valid(dm3_valid), .in_payload(dm3_payload),
        .out_valid(wb_valid), .out_payload(wb_payload)
    );

    assign out_valid = wb_valid;
    assign out_tag   = wb_payload.tag;
    assign out_rd    = wb_payload.rd;
    assign out_load  = wb_payload.load_kind;

    // ~~~~~~~~~~~~~~~~~~~~
    // hazard control
    // ~~~~~~~~~~~~~~~~~~~~
    assign out_stall_req = wb_valid && !out_ready;
    assign ex_mispredict = ex_valid && ex_payload.mispredict;

    // bubbles carry stale payload, mask their load code.
    assign dm1_load = dm1_valid ? dm1_payload.load_kind : load_none;
    assign dm2_load = dm2_valid ? dm2_payload.load_kind : load_none;
    assign dm3_load = dm3_valid ? dm3_payload.load_kind : load_none;

    hazard_control_unit u_hazard (
        .in_valid      (in_valid),
        .out_stall_req (out_stall_req),
        .ex_mispredict (ex_mispredict),
        .ex_rs1        (ex_payload.rs1),
        .ex_rs2        (ex_payload.rs2),
        .dm1_rd        (dm1_payload.rd),
        .dm1_load      (dm1_load),
        .dm2_rd        (dm2_payload.rd),
        .dm2_load      (dm2_load),
        .dm3_rd        (dm3_payload.rd),
        .dm3_load      (dm3_load),
        .clear_if      (clear_if),
        .clear_id      (clear_id),
        .clear_ex      (clear_ex),
        .stall_pc_if   (stall_pc_if),
        .stall_id      (stall_id),
        .stall_ex      (stall_ex),
        .stall_dm      (stall_dm)
    );

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   clear,
    input  logic                   in_valid,
    input  logic [tag_w-1:0]       in_tag,
    input  logic [reg_addr_w-1:0]  in_rs1,
    input  logic [reg_addr_w-1:0]  in_rs2,
    input  logic [reg_addr_w-1:0]  in_rd,
    input  logic [load_kind_w-1:0] in_load,
    input  logic                   in_mispredict,
    output logic                   in_ready,
    output logic                   if_valid,
    output instr_t                 if_payload
);

    logic   take;
    instr_t desc;

    assign in_ready = !stall;
    assign take     = in_valid && in_ready;

    // pack the loose descriptor.
    assign desc = '{tag: in_tag, rs1: in_rs1, rs2: in_rs2, rd: in_rd,
                    load_kind: in_load, mispredict: in_mispredict};

    // ~~~~~~~~~~~~~~~~~~~~
    // IF register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            if_valid <= 1'b0;
        else if (take)
            if_valid <= 1'b1;  // new fetch lands even during a flush.
        else if (clear || !stall)
            if_valid <= 1'b0;  // flushed, or moved on with nothing behind.
    end

    always_ff @(posedge clk)
    begin
        if (take)
            if_payload <= desc;
    end

    // the hazard unit never flushes a held fetch, so a stall keeps IF intact.
    assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> ($stable(if_valid) && $stable(if_payload)))
        else $error("fetch_stage: capture while stalled");

endmodule

`default_nettype wire

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     clear,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    // ~~~~~~~~~~~~~~~~~~~~
    // valid bit
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (clear)
            out_valid <= 1'b0;  // bubble.
        else if (!stall)
            out_valid <= in_valid;
    end

    // payload only moves with the stage.
    always_ff @(posedge clk)
    begin
        if (!stall && !clear)
            out_payload <= in_payload;
    end

    // a held instruction must not change under a frozen stage.
    assert property (@(posedge clk) disable iff (!rst_n)
        (stall && out_valid) |=> (out_valid && $stable(out_payload)))
        else $error("stage_reg: payload changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/hazard_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_control_unit
    import pipe_pkg::*;
(
    input  logic                   in_valid,
    input  logic                   out_stall_req,
    input  logic                   ex_mispredict,
    input  logic [reg_addr_w-1:0]  ex_rs1,
    input  logic [reg_addr_w-1:0]  ex_rs2,
    input  logic [reg_addr_w-1:0]  dm1_rd,
    input  logic [load_kind_w-1:0] dm1_load,
    input  logic [reg_addr_w-1:0]  dm2_rd,
    input  logic [load_kind_w-1:0] dm2_load,
    input  logic [reg_addr_w-1:0]  dm3_rd,
    input  logic [load_kind_w-1:0] dm3_load,
    output logic                   clear_if,
    output logic                   clear_id,
    output logic                   clear_ex,
    output logic                   stall_pc_if,
    output logic                   stall_id,
    output logic                   stall_ex,
    output logic                   stall_dm
);

    logic dm1_hit;
    logic dm2_hit;
    logic dm3_hit;
    logic load_use;

    // ~~~~~~~~~~~~~~~~~~~~
    // load-use detection
    // ~~~~~~~~~~~~~~~~~~~~
    assign dm1_hit = (dm1_load != load_none) && ((ex_rs1 == dm1_rd) || (ex_rs2 == dm1_rd));
    assign dm2_hit = (dm2_load != load_none) && ((ex_rs1 == dm2_rd) || (ex_rs2 == dm2_rd));
    assign dm3_hit = (dm3_load != load_none) && ((ex_rs1 == dm3_rd) || (ex_rs2 == dm3_rd));

    assign load_use = dm1_hit || dm2_hit || dm3_hit;  // data not back before WB.

    // ~~~~~~~~~~~~~~~~~~~~
    // priority
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        clear_if    = 1'b0;
        clear_id    = 1'b0;
        clear_ex    = 1'b0;
        stall_pc_if = 1'b0;
        stall_id    = 1'b0;
        stall_ex    = 1'b0;
        stall_dm    = 1'b0;

        if (out_stall_req)
        begin
            // retire port full so the whole pipe freezes.
            stall_pc_if = 1'b1;
            stall_id    = 1'b1;
            stall_ex    = 1'b1;
            stall_dm    = 1'b1;
        end
        else if (load_use)
        begin
            stall_pc_if = 1'b1;
            stall_id    = 1'b1;
            stall_ex    = 1'b1;  // bubble into DM1 is made at the top.
        end
        else
        begin
            if (!in_valid)
            begin
                stall_pc_if = 1'b1;
                stall_id    = 1'b1;
                clear_ex    = 1'b1;
            end
            // EX is never held here, so a mispredict always acts.
            if (ex_mispredict)
            begin
                clear_if    = 1'b1;
                clear_id    = 1'b1;
                stall_pc_if = 1'b0;  // flush beats the fetch hold.
                stall_id    = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // field widths
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int reg_addr_w  = 5;  // x0..x31.
    localparam int tag_w       = 8;
    localparam int load_kind_w = 3;  // data cache load width code.

    // not a load.
    localparam logic [load_kind_w-1:0] load_none = '0;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage payloads
    // ~~~~~~~~~~~~~~~~~~~~

    // front end descriptor, IF through EX.
    typedef struct packed {
        logic [tag_w-1:0]       tag;
        logic [reg_addr_w-1:0]  rs1;
        logic [reg_addr_w-1:0]  rs2;
        logic [reg_addr_w-1:0]  rd;
        logic [load_kind_w-1:0] load_kind;
        logic                   mispredict;
    } instr_t;

    // back end descriptor, DM1 through WB.
    // operands and branch state are dead past EX.
    typedef struct packed {
        logic [tag_w-1:0]       tag;
        logic [reg_addr_w-1:0]  rd;
        logic [load_kind_w-1:0] load_kind;
    } mem_t;

endpackage

`default_nettype wire
